// File: rvPkg.sv
package rvPkg;

    // Memory depths in 32-bit words
    localparam int ImemWords = 256;
    localparam int DmemWords = 256;

    localparam logic [31:0] ResetPc = 32'h0000_0000;

    // addi x0,x0,0
    localparam logic [31:0] Nop = 32'h0000_0013;

    typedef enum logic [6:0] {
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opReg    = 7'b0110011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSlt   = 4'd5,
        aluSll   = 4'd6,
        aluSrl   = 4'd7,
        aluPassB = 4'd8
    } aluOpE;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immSrcE;

    // resultSrc set means the result comes from data memory
    typedef struct packed {
        logic  regWrite;
        logic  resultSrc;
        logic  memWrite;
        aluOpE aluCtrl;
        logic  aluSrc;
    } ctrlS;

    typedef struct packed {
        ctrlS        ctrl;
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] extImm;
    } idExS;

    typedef struct packed {
        logic        regWrite;
        logic        resultSrc;
        logic        memWrite;
        logic [31:0] aluOut;
        logic [31:0] writeData;
        logic [4:0]  rd;
    } exMemS;

    typedef struct packed {
        logic        regWrite;
        logic [31:0] result;
        logic [4:0]  rd;
    } memWbS;

endpackage

// File: fetchStage.sv
`timescale 1ns/10ps

module fetchStage (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stallF,
    input  logic        stallD,
    input  logic        flushD,
    input  logic        pcSrcD,
    input  logic [31:0] pcBranchD,
    input  logic        progWe,
    input  logic [7:0]  progAddr,
    input  logic [31:0] progData,
    output logic [31:0] instrD,
    output logic [31:0] pcD
);
    import rvPkg::*;

    logic [31:0] imem [ImemWords];
    logic [31:0] pcF;
    logic [31:0] instrF;

    // Program load port, usable at any time
    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    assign instrF = imem[pcF[$clog2(ImemWords)+1:2]];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcF <= ResetPc;
        end else if (!stallF) begin
            pcF <= pcSrcD ? pcBranchD : pcF + 32'd4;
        end
    end

    // Fetch/decode register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrD <= Nop;
            pcD    <= ResetPc;
        end else if (flushD) begin
            instrD <= Nop;
            pcD    <= ResetPc;
        end else if (!stallD) begin
            instrD <= instrF;
            pcD    <= pcF;
        end
    end

    // A redirect either flushes decode or waits behind a stall, never both
    assert property (@(posedge clk) disable iff (!rstN) pcSrcD |-> (flushD != stallD))
        else $error("fetchStage: redirect with flushD and stallD equal");

endmodule

// File: controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
    input  rvPkg::opcodeE opcode,
    input  logic [2:0]    funct3,
    input  logic          funct7b5,
    output rvPkg::ctrlS   ctrl,
    output rvPkg::immSrcE immSrc,
    output logic          isBeq,
    output logic          isBne,
    output logic          isJal,
    output logic          isJalr
);
    import rvPkg::*;

    always_comb begin
        ctrl   = '0;
        immSrc = immI;
        isBeq  = 1'b0;
        isBne  = 1'b0;
        isJal  = 1'b0;
        isJalr = 1'b0;
        case (opcode)
            opImm: begin
                immSrc = immI;
                ctrl.aluSrc = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluCtrl = aluAdd;
                    3'b010:  ctrl.aluCtrl = aluSlt;
                    3'b100:  ctrl.aluCtrl = aluXor;
                    3'b110:  ctrl.aluCtrl = aluOr;
                    3'b111:  ctrl.aluCtrl = aluAnd;
                    // Shifts by immediate are not supported
                    default: ctrl = '0;
                endcase
            end
            opLui: begin
                immSrc = immU;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluCtrl = aluPassB;
            end
            opReg: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluCtrl = funct7b5 ? aluSub : aluAdd;
                    3'b001:  ctrl.aluCtrl = aluSll;
                    3'b010:  ctrl.aluCtrl = aluSlt;
                    3'b100:  ctrl.aluCtrl = aluXor;
                    3'b101:  ctrl.aluCtrl = aluSrl;
                    3'b110:  ctrl.aluCtrl = aluOr;
                    3'b111:  ctrl.aluCtrl = aluAnd;
                    default: ctrl = '0;
                endcase
            end
            opLoad: begin
                immSrc = immI;
                ctrl.regWrite = 1'b1;
                ctrl.resultSrc = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluCtrl = aluAdd;
            end
            opStore: begin
                immSrc = immS;
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluCtrl = aluAdd;
            end
            opBranch: begin
                // Resolved in decode, nothing goes down the pipe
                immSrc = immB;
                isBeq = (funct3 == 3'b000);
                isBne = (funct3 == 3'b001);
            end
            opJal: begin
                immSrc = immJ;
                isJal = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluCtrl = aluPassB;
            end
            opJalr: begin
                immSrc = immI;
                isJalr = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluCtrl = aluPassB;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    output logic [31:0] a0
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Write-through so decode sees the write-back value this cycle
    assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

    assign a0 = regs[10];

endmodule

// File: decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
    input  logic         clk,
    input  logic         rstN,
    input  logic         flushE,
    input  logic [31:0]  instrD,
    input  logic [31:0]  pcD,
    input  rvPkg::memWbS wb,
    input  logic [31:0]  aluOutM,
    input  logic         forwardAD,
    input  logic         forwardBD,
    output rvPkg::idExS  idEx,
    output logic         pcSrcD,
    output logic [31:0]  pcBranchD,
    output logic         branchD,
    output logic [4:0]   rs1D,
    output logic [4:0]   rs2D,
    output logic [31:0]  a0
);
    import rvPkg::*;

    ctrlS        ctrlD;
    immSrcE      immSrcD;
    logic        isBeq;
    logic        isBne;
    logic        isJal;
    logic        isJalr;
    logic [31:0] rd1D;
    logic [31:0] rd2D;
    logic [31:0] extImmD;
    logic [31:0] srcAD;
    logic [31:0] srcBD;
    idExS        idExNext;

    controlUnit uControl (
        .opcode   (opcodeE'(instrD[6:0])),
        .funct3   (instrD[14:12]),
        .funct7b5 (instrD[30]),
        .ctrl     (ctrlD),
        .immSrc   (immSrcD),
        .isBeq    (isBeq),
        .isBne    (isBne),
        .isJal    (isJal),
        .isJalr   (isJalr)
    );

    regFile uRegFile (
        .clk  (clk),
        .rstN (rstN),
        .we   (wb.regWrite),
        .wa   (wb.rd),
        .wd   (wb.result),
        .ra1  (rs1D),
        .ra2  (rs2D),
        .rd1  (rd1D),
        .rd2  (rd2D),
        .a0   (a0)
    );

    assign rs1D = instrD[19:15];
    assign rs2D = instrD[24:20];

    always_comb begin
        case (immSrcD)
            immS:    extImmD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    extImmD = {{19{instrD[31]}}, instrD[31], instrD[7],
                                instrD[30:25], instrD[11:8], 1'b0};
            immJ:    extImmD = {{11{instrD[31]}}, instrD[31], instrD[19:12],
                                instrD[20], instrD[30:21], 1'b0};
            immU:    extImmD = {instrD[31:12], 12'b0};
            default: extImmD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    // Branch operands, memory-stage result forwarded in
    assign srcAD = forwardAD ? aluOutM : rd1D;
    assign srcBD = forwardBD ? aluOutM : rd2D;

    assign branchD = isBeq | isBne | isJalr;

    assign pcBranchD = isJalr ? ((srcAD + extImmD) & ~32'd1) : (pcD + extImmD);

    always_comb begin
        if (isBeq) begin
            pcSrcD = (srcAD == srcBD);
        end else if (isBne) begin
            pcSrcD = (srcAD != srcBD);
        end else begin
            pcSrcD = isJal | isJalr;
        end
    end

    always_comb begin
        idExNext.ctrl = ctrlD;
        idExNext.rd1 = rd1D;
        idExNext.rd2 = rd2D;
        idExNext.rs1 = rs1D;
        idExNext.rs2 = rs2D;
        idExNext.rd = instrD[11:7];
        // Link value rides through the ALU as operand B
        idExNext.extImm = (isJal | isJalr) ? pcD + 32'd4 : extImmD;
    end

    // Decode/execute register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else if (flushE) begin
            idEx <= '0;
        end else begin
            idEx <= idExNext;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) flushE |=> !idEx.ctrl.regWrite)
        else $error("decodeStage: bubble after flushE still writes a register");

endmodule

// File: executeStage.sv
`timescale 1ns/10ps

module executeStage (
    input  logic         clk,
    input  logic         rstN,
    input  rvPkg::idExS  idEx,
    input  logic [31:0]  resultW,
    input  logic [1:0]   forwardAE,
    input  logic [1:0]   forwardBE,
    output rvPkg::exMemS exMem
);
    import rvPkg::*;

    logic [31:0] srcA;
    logic [31:0] fwdB;
    logic [31:0] srcB;
    logic [31:0] aluOut;

    // 2 is the memory stage, 1 is write-back
    always_comb begin
        case (forwardAE)
            2'd1:    srcA = resultW;
            2'd2:    srcA = exMem.aluOut;
            default: srcA = idEx.rd1;
        endcase
        case (forwardBE)
            2'd1:    fwdB = resultW;
            2'd2:    fwdB = exMem.aluOut;
            default: fwdB = idEx.rd2;
        endcase
    end

    assign srcB = idEx.ctrl.aluSrc ? idEx.extImm : fwdB;

    always_comb begin
        case (idEx.ctrl.aluCtrl)
            aluAdd:   aluOut = srcA + srcB;
            aluSub:   aluOut = srcA - srcB;
            aluAnd:   aluOut = srcA & srcB;
            aluOr:    aluOut = srcA | srcB;
            aluXor:   aluOut = srcA ^ srcB;
            aluSlt:   aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
            aluSll:   aluOut = srcA << srcB[4:0];
            aluSrl:   aluOut = srcA >> srcB[4:0];
            aluPassB: aluOut = srcB;
            default:  aluOut = '0;
        endcase
    end

    // Execute/memory register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem.regWrite <= idEx.ctrl.regWrite;
            exMem.resultSrc <= idEx.ctrl.resultSrc;
            exMem.memWrite <= idEx.ctrl.memWrite;
            exMem.aluOut <= aluOut;
            exMem.writeData <= fwdB;
            exMem.rd <= idEx.rd;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        idEx.ctrl.aluCtrl inside {aluAdd, aluSub, aluAnd, aluOr, aluXor,
                                  aluSlt, aluSll, aluSrl, aluPassB})
        else $error("executeStage: illegal ALU operation %0d", idEx.ctrl.aluCtrl);

endmodule

// File: memWbStage.sv
`timescale 1ns/10ps

module memWbStage (
    input  logic         clk,
    input  logic         rstN,
    input  rvPkg::exMemS exMem,
    output rvPkg::memWbS memWb
);
    import rvPkg::*;

    localparam int AddrHi = $clog2(DmemWords) + 1;

    logic [31:0] dmem [DmemWords];
    logic [31:0] readData;
    logic [31:0] resultM;

    // Word addressed, byte offset ignored
    always_ff @(posedge clk) begin
        if (exMem.memWrite) begin
            dmem[exMem.aluOut[AddrHi:2]] <= exMem.writeData;
        end
    end

    assign readData = dmem[exMem.aluOut[AddrHi:2]];

    assign resultM = exMem.resultSrc ? readData : exMem.aluOut;

    // Memory/write-back register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWb <= '0;
        end else begin
            memWb.regWrite <= exMem.regWrite;
            memWb.result <= resultM;
            memWb.rd <= exMem.rd;
        end
    end

endmodule

// File: hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    input  logic         pcSrcD,
    input  logic [4:0]   rs1D,
    input  logic [4:0]   rs2D,
    input  logic         branchD,
    input  rvPkg::idExS  idEx,
    input  rvPkg::exMemS exMem,
    input  rvPkg::memWbS memWb,
    output logic         stallF,
    output logic         stallD,
    output logic         flushD,
    output logic         flushE,
    output logic         forwardAD,
    output logic         forwardBD,
    output logic [1:0]   forwardAE,
    output logic [1:0]   forwardBE
);

    logic mHit1E;
    logic mHit2E;
    logic wHit1E;
    logic wHit2E;
    logic eHitD;
    logic mHitD;
    logic lwStall;
    logic branchStall;

    // Execute operands, memory stage wins over write-back
    assign mHit1E = exMem.regWrite && exMem.rd != 5'd0 && exMem.rd == idEx.rs1;
    assign mHit2E = exMem.regWrite && exMem.rd != 5'd0 && exMem.rd == idEx.rs2;
    assign wHit1E = memWb.regWrite && memWb.rd != 5'd0 && memWb.rd == idEx.rs1;
    assign wHit2E = memWb.regWrite && memWb.rd != 5'd0 && memWb.rd == idEx.rs2;

    assign forwardAE = mHit1E ? 2'd2 : wHit1E ? 2'd1 : 2'd0;
    assign forwardBE = mHit2E ? 2'd2 : wHit2E ? 2'd1 : 2'd0;

    // Branch operands in decode take the memory-stage ALU result
    assign forwardAD = exMem.regWrite && !exMem.resultSrc && exMem.rd != 5'd0
                       && exMem.rd == rs1D;
    assign forwardBD = exMem.regWrite && !exMem.resultSrc && exMem.rd != 5'd0
                       && exMem.rd == rs2D;

    assign eHitD = idEx.rd != 5'd0 && (idEx.rd == rs1D || idEx.rd == rs2D);
    assign mHitD = exMem.rd != 5'd0 && (exMem.rd == rs1D || exMem.rd == rs2D);

    assign lwStall = idEx.ctrl.resultSrc && eHitD;

    // Result still in execute, or a load still in memory
    assign branchStall = branchD && ((idEx.ctrl.regWrite && eHitD)
                                     || (exMem.resultSrc && mHitD));

    assign stallD = lwStall | branchStall;
    assign stallF = stallD;
    assign flushE = stallD;
    assign flushD = pcSrcD && !stallD;

endmodule

// File: rvCore.sv
`timescale 1ns/10ps

module rvCore (
    input  logic        clk,
    input  logic        rstN,
    input  logic        progWe,
    input  logic [7:0]  progAddr,
    input  logic [31:0] progData,
    output logic [31:0] a0
);
    import rvPkg::*;

    logic        stallF;
    logic        stallD;
    logic        flushD;
    logic        flushE;
    logic        pcSrcD;
    logic [31:0] pcBranchD;
    logic [31:0] instrD;
    logic [31:0] pcD;
    logic        branchD;
    logic [4:0]  rs1D;
    logic [4:0]  rs2D;
    logic        forwardAD;
    logic        forwardBD;
    logic [1:0]  forwardAE;
    logic [1:0]  forwardBE;
    idExS        idEx;
    exMemS       exMem;
    memWbS       memWb;

    fetchStage uFetch (
        .clk       (clk),
        .rstN      (rstN),
        .stallF    (stallF),
        .stallD    (stallD),
        .flushD    (flushD),
        .pcSrcD    (pcSrcD),
        .pcBranchD (pcBranchD),
        .progWe    (progWe),
        .progAddr  (progAddr),
        .progData  (progData),
        .instrD    (instrD),
        .pcD       (pcD)
    );

    decodeStage uDecode (
        .clk       (clk),
        .rstN      (rstN),
        .flushE    (flushE),
        .instrD    (instrD),
        .pcD       (pcD),
        .wb        (memWb),
        .aluOutM   (exMem.aluOut),
        .forwardAD (forwardAD),
        .forwardBD (forwardBD),
        .idEx      (idEx),
        .pcSrcD    (pcSrcD),
        .pcBranchD (pcBranchD),
        .branchD   (branchD),
        .rs1D      (rs1D),
        .rs2D      (rs2D),
        .a0        (a0)
    );

    executeStage uExecute (
        .clk       (clk),
        .rstN      (rstN),
        .idEx      (idEx),
        .resultW   (memWb.result),
        .forwardAE (forwardAE),
        .forwardBE (forwardBE),
        .exMem     (exMem)
    );

    memWbStage uMemWb (
        .clk   (clk),
        .rstN  (rstN),
        .exMem (exMem),
        .memWb (memWb)
    );

    hazardUnit uHazard (
        .pcSrcD    (pcSrcD),
        .rs1D      (rs1D),
        .rs2D      (rs2D),
        .branchD   (branchD),
        .idEx      (idEx),
        .exMem     (exMem),
        .memWb     (memWb),
        .stallF    (stallF),
        .stallD    (stallD),
        .flushD    (flushD),
        .flushE    (flushE),
        .forwardAD (forwardAD),
        .forwardBD (forwardBD),
        .forwardAE (forwardAE),
        .forwardBE (forwardBE)
    );

endmodule

// File: rvCoreChecker.sv
`timescale 1ns/10ps

module rvCoreChecker (
    input logic        clk,
    input logic        rstN,
    input logic [31:0] a0,
    input logic [31:0] instrD
);

    // jal x0,0 marks the end of every program
    localparam logic [31:0] HaltWord = 32'h0000_006f;

    int   errorCount;
    int   checkCount;
    logic haltSeen;
    logic resetHeld;

    initial begin
        errorCount = 0;
        checkCount = 0;
        haltSeen   = 1'b0;
        resetHeld  = 1'b0;
    end

    // Sticky once the halt loop reaches decode
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            haltSeen <= 1'b0;
        end else if (instrD == HaltWord) begin
            haltSeen <= 1'b1;
        end
    end

    // Register file reads zero once reset has been held over a clock edge
    always @(posedge clk) begin
        if (!rstN && resetHeld && a0 !== 32'd0) begin
            errorCount++;
            $display("a0 is not zero while reset is held, it reads %h", a0);
        end
        resetHeld <= !rstN;
    end

    task automatic checkA0(input string name, input logic [31:0] expected,
                           input logic needHalt);
        checkCount++;
        if (a0 !== expected) begin
            errorCount++;
            $display("ERROR %s: expected %h, actual %h", name, expected, a0);
        end
        if (needHalt && !haltSeen) begin
            errorCount++;
            $display("%s: the program never reached its halt loop", name);
        end
    endtask

endmodule

// File: tbRvCore.sv
`timescale 1ns/10ps

module tbRvCore;
    import rvPkg::*;

    localparam int NumTests    = 6;
    localparam int MaxWords    = 16;
    localparam int ResetCycles = 8;
    localparam int EarlyCycles = 3;

    localparam logic [6:0]  OpImm    = 7'b0010011;
    localparam logic [6:0]  OpLoad   = 7'b0000011;
    localparam logic [6:0]  OpJalr   = 7'b1100111;
    localparam logic [4:0]  RegA0    = 5'd10;
    // jal x0,0 spins in place
    localparam logic [31:0] HaltWord = 32'h0000_006f;

    logic        clk;
    logic        rstN;
    logic        progWe;
    logic [7:0]  progAddr;
    logic [31:0] progData;
    logic [31:0] a0;

    integer      seed;
    int          cycleCount;
    int          cycleLimit;

    // Test table
    string       testName [NumTests];
    logic [31:0] prog     [NumTests][MaxWords];
    int          progLen  [NumTests];
    int          runLen   [NumTests];
    int          resetAt  [NumTests];
    logic [31:0] expA0    [NumTests];

    rvCore dut (
        .clk      (clk),
        .rstN     (rstN),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .a0       (a0)
    );

    rvCoreChecker uChecker (
        .clk    (clk),
        .rstN   (rstN),
        .a0     (dut.a0),
        .instrD (dut.instrD)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return encI(imm, rs1, 3'b000, rd, OpImm);
    endfunction

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic buildTests();
        logic [31:0] r;
        logic [11:0] imm1;
        logic [11:0] imm2;
        logic [31:0] v [32];
        r = $random(seed);
        imm1 = r[11:0];
        r = $random(seed);
        imm2 = r[11:0];

        // Dependent chain, forwarding from memory and write-back
        testName[0] = "arith";
        prog[0][0]  = addi(5, 0, imm1);
        prog[0][1]  = addi(6, 5, imm2);
        prog[0][2]  = rType(7'b0000000, 3'b000, 7, 5, 6);
        prog[0][3]  = rType(7'b0100000, 3'b000, 8, 7, 5);
        prog[0][4]  = rType(7'b0000000, 3'b111, 9, 8, 6);
        prog[0][5]  = rType(7'b0000000, 3'b110, 11, 9, 7);
        prog[0][6]  = rType(7'b0000000, 3'b100, 12, 11, 8);
        prog[0][7]  = rType(7'b0000000, 3'b010, 13, 12, 7);
        prog[0][8]  = encU(20'h12345, 14);
        prog[0][9]  = addi(15, 0, 12'd3);
        prog[0][10] = rType(7'b0000000, 3'b001, 16, 14, 15);
        prog[0][11] = rType(7'b0000000, 3'b101, 17, 16, 15);
        prog[0][12] = rType(7'b0000000, 3'b000, 18, 17, 13);
        prog[0][13] = rType(7'b0000000, 3'b100, RegA0, 18, 12);
        progLen[0]  = 14;
        runLen[0]   = 40;
        resetAt[0]  = 0;
        v[5]  = sext12(imm1);
        v[6]  = v[5] + sext12(imm2);
        v[7]  = v[5] + v[6];
        v[8]  = v[7] - v[5];
        v[9]  = v[8] & v[6];
        v[11] = v[9] | v[7];
        v[12] = v[11] ^ v[8];
        v[13] = ($signed(v[12]) < $signed(v[7])) ? 32'd1 : 32'd0;
        v[14] = 32'h1234_5000;
        v[16] = v[14] << 3;
        v[17] = v[16] >> 3;
        v[18] = v[17] + v[13];
        expA0[0] = v[18] ^ v[12];

        // Store then load back, with a load-use stall
        testName[1] = "loadStore";
        prog[1][0]  = addi(5, 0, 12'h123);
        prog[1][1]  = encU(20'hABCDE, 6);
        prog[1][2]  = rType(7'b0000000, 3'b000, 6, 6, 5);
        prog[1][3]  = addi(7, 0, 12'h040);
        prog[1][4]  = encS(12'd4, 6, 7);
        prog[1][5]  = encI(12'd4, 7, 3'b010, 8, OpLoad);
        prog[1][6]  = rType(7'b0000000, 3'b000, RegA0, 8, 0);
        progLen[1]  = 7;
        runLen[1]   = 40;
        resetAt[1]  = 0;
        expA0[1]    = 32'hABCD_E000 + 32'h123;

        // Wrong-path addi after each taken branch must vanish
        testName[2] = "branches";
        prog[2][0]  = addi(5, 0, 12'd5);
        prog[2][1]  = addi(6, 0, 12'd5);
        prog[2][2]  = addi(RegA0, 0, 12'd1);
        prog[2][3]  = addi(7, 6, 12'd0);
        prog[2][4]  = encB(13'd8, 7, 5, 3'b000);
        prog[2][5]  = addi(RegA0, RegA0, 12'h100);
        prog[2][6]  = encB(13'd8, 7, 5, 3'b001);
        prog[2][7]  = addi(RegA0, RegA0, 12'd2);
        prog[2][8]  = addi(8, 0, 12'd9);
        prog[2][9]  = encB(13'd8, 5, 8, 3'b001);
        prog[2][10] = addi(RegA0, RegA0, 12'h200);
        prog[2][11] = encB(13'd8, 5, 8, 3'b000);
        prog[2][12] = addi(RegA0, RegA0, 12'd4);
        progLen[2]  = 13;
        runLen[2]   = 40;
        resetAt[2]  = 0;
        expA0[2]    = 32'd1 + 32'd2 + 32'd4;

        // jal links to a0, call and return through jalr
        testName[3] = "jumps";
        prog[3][0]  = addi(5, 0, 12'h024);
        prog[3][1]  = encJ(21'd12, RegA0);
        prog[3][2]  = addi(RegA0, 0, 12'h011);
        prog[3][3]  = addi(RegA0, 0, 12'h022);
        prog[3][4]  = addi(6, RegA0, 12'd0);
        prog[3][5]  = encI(12'd0, 5, 3'b000, 1, OpJalr);
        prog[3][6]  = rType(7'b0000000, 3'b000, RegA0, RegA0, 7);
        prog[3][7]  = HaltWord;
        prog[3][8]  = addi(RegA0, 0, 12'h033);
        prog[3][9]  = addi(7, 0, 12'h100);
        prog[3][10] = encI(12'd0, 1, 3'b000, 0, OpJalr);
        progLen[3]  = 11;
        runLen[3]   = 40;
        resetAt[3]  = 0;
        // Link of the jal at byte 4 plus the value set in the callee
        expA0[3]    = 32'd4 + 32'd4 + 32'h100;

        // Accumulates into a0, so stale registers would show
        testName[4] = "midReset";
        prog[4][0]  = addi(RegA0, RegA0, 12'h021);
        prog[4][1]  = addi(RegA0, RegA0, 12'h021);
        progLen[4]  = 2;
        runLen[4]   = 30;
        resetAt[4]  = 20;
        expA0[4]    = 32'h21 + 32'h21;

        testName[5] = "regZero";
        prog[5][0]  = addi(0, 0, 12'h055);
        prog[5][1]  = addi(5, 0, 12'h03c);
        prog[5][2]  = encI(12'h300, 5, 3'b110, 6, OpImm);
        prog[5][3]  = encI(12'h0f0, 6, 3'b111, 6, OpImm);
        prog[5][4]  = encI(12'h7ff, 6, 3'b100, 6, OpImm);
        prog[5][5]  = encI(12'h7ff, 6, 3'b010, 7, OpImm);
        prog[5][6]  = rType(7'b0000000, 3'b000, 0, 6, 7);
        prog[5][7]  = rType(7'b0000000, 3'b000, RegA0, 0, 6);
        prog[5][8]  = rType(7'b0000000, 3'b000, RegA0, RegA0, 7);
        progLen[5]  = 9;
        runLen[5]   = 40;
        resetAt[5]  = 0;
        expA0[5]    = (((32'h03c | 32'h300) & 32'h0f0) ^ 32'h7ff) + 32'd1;
    endtask

    function automatic int computeLimit();
        int total;
        total = 0;
        for (int t = 0; t < NumTests; t++) begin
            total += ResetCycles + 1 + ImemWords + 1 + runLen[t];
            if (resetAt[t] > 0) begin
                total += resetAt[t] + ResetCycles + 1 + EarlyCycles;
            end
        end
        return total + total / 5;
    endfunction

    task automatic applyReset();
        @(negedge clk);
        rstN = 1'b0;
        repeat (ResetCycles) @(negedge clk);
    endtask

    // Whole memory is written, unused words get the halt loop
    task automatic loadProgram(input int t);
        for (int i = 0; i < ImemWords; i++) begin
            @(negedge clk);
            progWe   = 1'b1;
            progAddr = i[7:0];
            progData = (i < progLen[t]) ? prog[t][i] : HaltWord;
        end
        @(negedge clk);
        progWe = 1'b0;
    endtask

    task automatic runTest(input int t);
        applyReset();
        loadProgram(t);
        rstN = 1'b1;
        if (resetAt[t] > 0) begin
            repeat (resetAt[t]) @(negedge clk);
            uChecker.checkA0({testName[t], " before reset"}, expA0[t], 1'b0);
            applyReset();
            rstN = 1'b1;
            // Nothing can reach write-back this early
            repeat (EarlyCycles) @(negedge clk);
            uChecker.checkA0({testName[t], " after reset"}, 32'd0, 1'b0);
        end
        repeat (runLen[t]) @(negedge clk);
        uChecker.checkA0(testName[t], expA0[t], 1'b1);
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run went past %0d cycles", cycleLimit);
            $display("Tests: %0d, checks: %0d, errors: %0d", NumTests,
                     uChecker.checkCount, uChecker.errorCount);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        cycleCount = 0;
        seed       = 32'h1b889c82;
        buildTests();
        cycleLimit = computeLimit();
        for (int t = 0; t < NumTests; t++) begin
            runTest(t);
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", NumTests,
                 uChecker.checkCount, uChecker.errorCount);
        if (uChecker.errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: rvCore.f
rvPkg.sv
fetchStage.sv
controlUnit.sv
regFile.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
hazardUnit.sv
rvCore.sv
rvCoreChecker.sv
tbRvCore.sv

// File: Bender.yml
package:
  name: rvCore

sources:
  - files:
      - rvPkg.sv
      - fetchStage.sv
      - controlUnit.sv
      - regFile.sv
      - decodeStage.sv
      - executeStage.sv
      - memWbStage.sv
      - hazardUnit.sv
      - rvCore.sv
  - target: test
    files:
      - rvCoreChecker.sv
      - tbRvCore.sv
